//--- rtl/ememory_config.svh
`ifndef EMEMORY_CONFIG_SVH
`define EMEMORY_CONFIG_SVH

// Word address width, 1K doublewords
`define EMEM_MAW 10

// Input queue depth, equal to the credits the sender starts with
`define EMEM_IN_CREDITS 4

// Credits for the response path after reset
`define EMEM_OUT_CREDITS 2

// Response queue depth
`define EMEM_RSP_DEPTH 4

`endif

//--- rtl/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   // Access size of a mesh transaction
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_SHORT  = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_e;

   typedef logic [4:0]  ctrlmode_t;
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // 104-bit mesh packet, msb first
   // For doubles, data holds the low word and srcaddr the high word
   typedef struct packed {
      logic      write;
      datamode_e datamode;
      ctrlmode_t ctrlmode;
      addr_t     dstaddr;
      data_t     data;
      addr_t     srcaddr;
   } emesh_packet_t;

   // Packet width, for anyone needing a flat vector
   localparam int unsigned PACKET_W = $bits(emesh_packet_t);

endpackage

`default_nettype wire

//--- rtl/emem_pkg.sv
`default_nettype none

`include "ememory_config.svh"

package emem_pkg;

   // Doubleword address into the memory array
   typedef logic [`EMEM_MAW-1:0] mem_addr_t;

   // Memory data word and per-byte write enables
   typedef logic [63:0] mem_data_t;
   typedef logic [7:0]  mem_wen_t;

   // Byte offset within a doubleword
   typedef logic [2:0]  byte_off_t;

   // What result needs to shape a read response
   typedef struct packed {
      emesh_pkg::datamode_e datamode;
      emesh_pkg::ctrlmode_t ctrlmode;
      byte_off_t            offset;
      emesh_pkg::addr_t     retaddr;
   } rd_ctx_t;

endpackage

`default_nettype wire

//--- rtl/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

   // Request side, driven by decode
   logic                 en;
   logic                 rd;
   emem_pkg::mem_wen_t   wen;
   emem_pkg::mem_addr_t  addr;
   emem_pkg::mem_data_t  din;
   emem_pkg::rd_ctx_t    ctx;

   // Read return, driven by execute
   logic                 rd_valid;
   emem_pkg::mem_data_t  dout;
   emem_pkg::rd_ctx_t    rd_ctx;

   modport decode  (output en, rd, wen, addr, din, ctx);
   modport execute (input en, rd, wen, addr, din, ctx,
                    output rd_valid, dout, rd_ctx);
   // result watches read issue to track reserved slots
   modport result  (input en, rd, rd_valid, dout, rd_ctx);

endinterface

`default_nettype wire

//--- rtl/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
   parameter type T         = logic,
   parameter int unsigned DEPTH = 4
) (
   input  wire logic clk,
   input  wire logic nreset,
   input  wire logic push,
   input  wire T     push_data,
   input  wire logic pop,
   output T          pop_data,
   output logic      empty,
   output logic      full
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   T                 buf_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(DEPTH));
   // A push into a full queue is fine when the head leaves in the same cycle
   assign do_pop  = pop & ~empty;
   assign do_push = push & (~full | do_pop);

   // Show-ahead head entry
   assign pop_data = buf_q[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         buf_q[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/emem_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ememory_config.svh"

module emem_decode (
   input  wire logic                     clk,
   input  wire logic                     nreset,
   input  wire logic                     access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   input  wire logic                     rsp_slot_free,
   output logic                          credit_out,
   mem_req_if.decode                     req
);

   emesh_pkg::emesh_packet_t head;
   logic                     in_empty;
   logic                     issue;
   logic [31:0]              din_word;

   // Input packet queue, one entry per sender credit
   credit_fifo #(
      .T     (emesh_pkg::emesh_packet_t),
      .DEPTH (`EMEM_IN_CREDITS)
   ) u_in_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .push      (access_in),
      .push_data (packet_in),
      .pop       (issue),
      .pop_data  (head),
      .empty     (in_empty),
      .full      ()
   );

   // Reads wait for a free response slot, writes go straight through
   assign issue = ~in_empty & (head.write | rsp_slot_free);

   assign req.en   = issue;
   assign req.rd   = ~head.write;
   assign req.addr = head.dstaddr[`EMEM_MAW+2:3];

   // Replicate the sub-word across 32 bits
   always_comb
   begin
      case (head.datamode)
         emesh_pkg::DM_BYTE:  din_word = {4{head.data[7:0]}};
         emesh_pkg::DM_SHORT: din_word = {2{head.data[15:0]}};
         default:             din_word = head.data;
      endcase
   end

   // Doubles carry their high word in srcaddr
   assign req.din = (head.datamode == emesh_pkg::DM_DOUBLE) ?
                    {head.srcaddr, din_word} : {din_word, din_word};

   // Byte enables by size and offset
   always_comb
   begin
      casez ({head.write, head.datamode, head.dstaddr[2:0]})
         6'b1_00_000: req.wen = 8'b0000_0001;
         6'b1_00_001: req.wen = 8'b0000_0010;
         6'b1_00_010: req.wen = 8'b0000_0100;
         6'b1_00_011: req.wen = 8'b0000_1000;
         6'b1_00_100: req.wen = 8'b0001_0000;
         6'b1_00_101: req.wen = 8'b0010_0000;
         6'b1_00_110: req.wen = 8'b0100_0000;
         6'b1_00_111: req.wen = 8'b1000_0000;
         6'b1_01_00?: req.wen = 8'b0000_0011;
         6'b1_01_01?: req.wen = 8'b0000_1100;
         6'b1_01_10?: req.wen = 8'b0011_0000;
         6'b1_01_11?: req.wen = 8'b1100_0000;
         6'b1_10_0??: req.wen = 8'b0000_1111;
         6'b1_10_1??: req.wen = 8'b1111_0000;
         6'b1_11_???: req.wen = 8'b1111_1111;
         default:     req.wen = 8'b0000_0000;
      endcase
   end

   // Context that rides along with the read
   always_comb
   begin
      req.ctx          = '0;
      req.ctx.datamode = head.datamode;
      req.ctx.ctrlmode = head.ctrlmode;
      req.ctx.offset   = head.dstaddr[2:0];
      req.ctx.retaddr  = head.srcaddr;
   end

   // One credit back per consumed packet
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         credit_out <= 1'b0;
      else
         credit_out <= issue;
   end

endmodule

`default_nettype wire

//--- rtl/emem_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "ememory_config.svh"

module emem_execute (
   input  wire logic  clk,
   input  wire logic  nreset,
   mem_req_if.execute mem
);

   localparam int unsigned WORDS = 2 ** `EMEM_MAW;

   emem_pkg::mem_data_t ram [WORDS];

   // Byte-masked write, registered read
   always_ff @(posedge clk)
   begin
      if (mem.en)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (mem.wen[i])
               ram[mem.addr][8*i +: 8] <= mem.din[8*i +: 8];
         end
         if (mem.rd)
         begin
            mem.dout   <= ram[mem.addr];
            mem.rd_ctx <= mem.ctx;
         end
      end
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         mem.rd_valid <= 1'b0;
      else
         mem.rd_valid <= mem.en & mem.rd;
   end

endmodule

`default_nettype wire

//--- rtl/emem_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "ememory_config.svh"

module emem_result (
   input  wire logic                clk,
   input  wire logic                nreset,
   input  wire logic                credit_in,
   output logic                     rsp_slot_free,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   mem_req_if.result                mem
);

   localparam int unsigned RSV_W = $clog2(`EMEM_RSP_DEPTH + 1);
   localparam int unsigned CRD_W = $clog2(`EMEM_OUT_CREDITS + 1) + 1;

   emesh_pkg::emesh_packet_t rsp;
   logic [31:0]              data_al;
   logic [31:0]              src_al;
   logic                     rsp_empty;
   logic [RSV_W-1:0]         rsv_cnt;
   logic [CRD_W-1:0]         out_credits;

   // Pull the addressed bytes down to bit 0
   always_comb
   begin
      src_al = '0;
      case (mem.rd_ctx.datamode)
         emesh_pkg::DM_BYTE:
            data_al = {24'b0, mem.dout[8*mem.rd_ctx.offset +: 8]};
         emesh_pkg::DM_SHORT:
            data_al = {16'b0, mem.dout[16*mem.rd_ctx.offset[2:1] +: 16]};
         emesh_pkg::DM_WORD:
            data_al = mem.dout[32*mem.rd_ctx.offset[2] +: 32];
         default:
         begin
            data_al = mem.dout[31:0];
            src_al  = mem.dout[63:32];
         end
      endcase
   end

   // Response goes back as a write to the requester
   always_comb
   begin
      rsp.write    = 1'b1;
      rsp.datamode = mem.rd_ctx.datamode;
      rsp.ctrlmode = mem.rd_ctx.ctrlmode;
      rsp.dstaddr  = mem.rd_ctx.retaddr;
      rsp.data     = data_al;
      rsp.srcaddr  = src_al;
   end

   credit_fifo #(
      .T     (emesh_pkg::emesh_packet_t),
      .DEPTH (`EMEM_RSP_DEPTH)
   ) u_rsp_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .push      (mem.rd_valid),
      .push_data (rsp),
      .pop       (access_out),
      .pop_data  (packet_out),
      .empty     (rsp_empty),
      .full      ()
   );

   // Send whenever a response waits and the receiver has room
   assign access_out = ~rsp_empty & (out_credits != '0);

   // Slots reserved by issued reads plus those still queued
   assign rsp_slot_free = (rsv_cnt < RSV_W'(`EMEM_RSP_DEPTH));

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rsv_cnt <= '0;
      else
      begin
         case ({mem.en & mem.rd, access_out})
            2'b10:   rsv_cnt <= rsv_cnt + 1'b1;
            2'b01:   rsv_cnt <= rsv_cnt - 1'b1;
            default: rsv_cnt <= rsv_cnt;
         endcase
      end
   end

   // Output credits, spend and return may coincide
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         out_credits <= CRD_W'(`EMEM_OUT_CREDITS);
      else
      begin
         case ({access_out, credit_in})
            2'b10:   out_credits <= out_credits - 1'b1;
            2'b01:   out_credits <= out_credits + 1'b1;
            default: out_credits <= out_credits;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/ememory.sv
`timescale 1ns/1ps
`default_nettype none

module ememory (
   input  wire logic                     clk,
   input  wire logic                     nreset,

   // Requests from the mesh
   input  wire logic                     access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   output logic                          credit_out,

   // Read responses back to the mesh
   output logic                          access_out,
   output emesh_pkg::emesh_packet_t      packet_out,
   input  wire logic                     credit_in
);

   logic rsp_slot_free;

   mem_req_if u_req ();

   emem_decode u_decode (
      .clk           (clk),
      .nreset        (nreset),
      .access_in     (access_in),
      .packet_in     (packet_in),
      .rsp_slot_free (rsp_slot_free),
      .credit_out    (credit_out),
      .req           (u_req.decode)
   );

   emem_execute u_execute (
      .clk    (clk),
      .nreset (nreset),
      .mem    (u_req.execute)
   );

   emem_result u_result (
      .clk           (clk),
      .nreset        (nreset),
      .credit_in     (credit_in),
      .rsp_slot_free (rsp_slot_free),
      .access_out    (access_out),
      .packet_out    (packet_out),
      .mem           (u_req.result)
   );

endmodule

`default_nettype wire

//--- verif/ememory_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ememory_config.svh"

module ememory_tb;

   localparam int BP_READS = `EMEM_OUT_CREDITS + `EMEM_IN_CREDITS + `EMEM_RSP_DEPTH + 2;
   localparam int BP_CONSUMED = `EMEM_OUT_CREDITS + `EMEM_RSP_DEPTH;
   localparam int TOTAL_PACKETS = 16 + 29 + 15 + BP_READS + 48;
   localparam int MODEL_BYTES = 8 * (2 ** `EMEM_MAW);

   logic clk = 1'b0;
   logic nreset;
   logic access_in;
   emesh_pkg::emesh_packet_t packet_in;
   logic credit_out;
   logic access_out;
   emesh_pkg::emesh_packet_t packet_out;
   logic credit_in;

   logic [7:0] model [MODEL_BYTES];
   emesh_pkg::emesh_packet_t exp_q [$];
   emesh_pkg::emesh_packet_t rsp_exp;
   logic [`EMEM_MAW-1:0] written [8];
   int sent = 0;
   int credits_back = 0;
   int rx_count = 0;
   int owed = 0;
   int credits_given = 0;
   bit hold = 1'b0;
   bit bp_done;

   always #4 clk = ~clk;

   ememory u_dut (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .credit_out (credit_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .credit_in  (credit_in)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   function automatic emesh_pkg::emesh_packet_t make_pkt(input logic wr,
      input emesh_pkg::datamode_e dm, input emesh_pkg::ctrlmode_t ctrl,
      input logic [31:0] dst, input logic [31:0] data, input logic [31:0] src);
      return '{wr, dm, ctrl, dst, data, src};
   endfunction

   // Sub-word accesses land on their natural boundary
   function automatic int align_off(input emesh_pkg::datamode_e dm, input logic [2:0] off);
      int n;
      n = 1 << dm;
      return off - (off % n);
   endfunction

   function automatic void apply_write(input emesh_pkg::emesh_packet_t p);
      int base;
      int off;
      logic [63:0] src;
      base = 8 * p.dstaddr[`EMEM_MAW+2:3];
      off = align_off(p.datamode, p.dstaddr[2:0]);
      src = {p.srcaddr, p.data};
      for (int i = 0; i < (1 << p.datamode); i++)
         model[base + off + i] = src[8*i +: 8];
   endfunction

   // Read data comes back low-aligned, the upper half of a double in srcaddr
   function automatic emesh_pkg::emesh_packet_t expect_rsp(input emesh_pkg::emesh_packet_t rq);
      emesh_pkg::emesh_packet_t r;
      int base;
      int off;
      base = 8 * rq.dstaddr[`EMEM_MAW+2:3];
      off = align_off(rq.datamode, rq.dstaddr[2:0]);
      r = make_pkt(1'b1, rq.datamode, rq.ctrlmode, rq.srcaddr, 32'h0, 32'h0);
      for (int i = 0; i < (1 << rq.datamode); i++)
      begin
         if (i < 4)
            r.data[8*i +: 8] = model[base + off + i];
         else
            r.srcaddr[8*(i-4) +: 8] = model[base + off + i];
      end
      return r;
   endfunction

   task automatic send_pkt(input emesh_pkg::emesh_packet_t p);
      @(posedge clk);
      // No sender credit left
      while (sent - credits_back >= `EMEM_IN_CREDITS)
      begin
         access_in <= 1'b0;
         @(posedge clk);
      end
      access_in <= 1'b1;
      packet_in <= p;
      sent++;
      if (p.write)
         apply_write(p);
      else
         exp_q.push_back(expect_rsp(p));
   endtask

   task automatic end_burst();
      @(posedge clk);
      access_in <= 1'b0;
   endtask

   task automatic drain_responses();
      while (exp_q.size() != 0)
         @(posedge clk);
   endtask

   // Input credits counted mid-cycle, ready for the sender at the next edge
   always @(negedge clk)
   begin
      if (credit_out)
         credits_back++;
   end

   // Response checker and output credit return
   always @(posedge clk)
   begin
      if (access_out)
      begin
         assert (exp_q.size() > 0)
         else fail_run("A response arrived while no read was outstanding");
         // Never more responses than output credits granted
         assert (rx_count < `EMEM_OUT_CREDITS + credits_given)
         else fail_run($sformatf("[ERROR] %0t: response %0d sent with %0d credits returned",
                                 $time, rx_count + 1, credits_given));
         rsp_exp = exp_q.pop_front();
         assert (packet_out == rsp_exp)
         else fail_run($sformatf("[ERROR] %0t: response %h, expected %h",
                                 $time, packet_out, rsp_exp));
         rx_count++;
         owed++;
      end
      if (!hold && owed > 0)
      begin
         credit_in <= 1'b1;
         owed--;
         credits_given++;
      end
      else
         credit_in <= 1'b0;
   end

   task automatic reset_check();
      repeat (6)
      begin
         @(posedge clk);
         assert (!access_out && !credit_out)
         else fail_run($sformatf("[ERROR] %0t: output active after reset", $time));
      end
   endtask

   task automatic double_rw();
      for (int i = 0; i < 8; i++)
      begin
         written[i] = `EMEM_MAW'($urandom);
         send_pkt(make_pkt(1'b1, emesh_pkg::DM_DOUBLE, 5'd0, {written[i], 3'b000},
                           $urandom, $urandom));
      end
      for (int i = 0; i < 8; i++)
         send_pkt(make_pkt(1'b0, emesh_pkg::DM_DOUBLE, 5'($urandom), {written[i], 3'b000},
                           32'h0, $urandom));
      end_burst();
      drain_responses();
   endtask

   task automatic partial_writes();
      send_pkt(make_pkt(1'b1, emesh_pkg::DM_DOUBLE, 5'd0, 32'h28, $urandom, $urandom));
      // Read the whole doubleword back after every sub-word write
      for (int s = 0; s < 3; s++)
         for (int off = 0; off < 8; off += (1 << s))
         begin
            send_pkt(make_pkt(1'b1, emesh_pkg::datamode_e'(s), 5'd0, 32'h28 + off,
                              $urandom, 32'h0));
            send_pkt(make_pkt(1'b0, emesh_pkg::DM_DOUBLE, 5'(s), 32'h28, 32'h0,
                              32'h1000 + off));
         end
      end_burst();
      drain_responses();
   endtask

   task automatic subword_reads();
      send_pkt(make_pkt(1'b1, emesh_pkg::DM_DOUBLE, 5'd0, 32'h48, $urandom, $urandom));
      for (int s = 0; s < 3; s++)
         for (int off = 0; off < 8; off += (1 << s))
            send_pkt(make_pkt(1'b0, emesh_pkg::datamode_e'(s), 5'($urandom), 32'h48 + off,
                              32'h0, $urandom));
      end_burst();
      drain_responses();
   endtask

   task automatic credit_backpressure();
      int rx_base;
      int cb_base;
      // Let credits owed from earlier responses go back first
      repeat (3) @(posedge clk);
      rx_base = rx_count;
      cb_base = credits_back;
      hold <= 1'b1;
      bp_done = 1'b0;
      fork
         begin
            for (int i = 0; i < BP_READS; i++)
               send_pkt(make_pkt(1'b0, emesh_pkg::DM_DOUBLE, 5'(i), {written[i % 8], 3'b000},
                                 32'h0, 32'h2000 + i));
            end_burst();
            bp_done = 1'b1;
         end
      join_none
      // Long enough for both queues to fill and the input to stall
      repeat (40) @(posedge clk);
      assert (rx_count - rx_base == `EMEM_OUT_CREDITS)
      else fail_run($sformatf("[ERROR] %0t: %0d responses sent without credit return",
                              $time, rx_count - rx_base));
      // Sent responses plus a full response queue, the rest stalls
      assert (credits_back - cb_base == BP_CONSUMED)
      else fail_run($sformatf("[ERROR] %0t: %0d input credits under back-pressure, expected %0d",
                              $time, credits_back - cb_base, BP_CONSUMED));
      hold <= 1'b0;
      while (!bp_done)
         @(posedge clk);
      drain_responses();
      repeat (2) @(posedge clk);
      assert (credits_back == sent)
      else fail_run($sformatf("[ERROR] %0t: credits back %0d for %0d packets",
                              $time, credits_back, sent));
   endtask

   task automatic random_mix();
      logic [31:0] addr;
      for (int i = 0; i < 8; i++)
         send_pkt(make_pkt(1'b1, emesh_pkg::DM_DOUBLE, 5'd0, 32'h80 + 8 * i, $urandom, $urandom));
      for (int i = 0; i < 40; i++)
      begin
         addr = 32'h80 + 8 * $urandom_range(7, 0) + $urandom_range(7, 0);
         send_pkt(make_pkt(1'($urandom), emesh_pkg::datamode_e'($urandom_range(3, 0)),
                           5'($urandom), addr, $urandom, $urandom));
      end
      end_burst();
      drain_responses();
   endtask

   initial
   begin
      repeat (TOTAL_PACKETS * 40) @(posedge clk);
      fail_run("Timeout: the tests did not complete in the allowed time");
   end

   initial
   begin
      void'($urandom(32'hdb16));
      nreset = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      credit_in = 1'b0;
      repeat (2) @(posedge clk);
      nreset <= 1'b1;
      reset_check();
      double_rw();
      partial_writes();
      subword_reads();
      credit_backpressure();
      random_mix();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- ememory.f
+incdir+rtl
rtl/emesh_pkg.sv
rtl/emem_pkg.sv
rtl/mem_req_if.sv
rtl/credit_fifo.sv
rtl/emem_decode.sv
rtl/emem_execute.sv
rtl/emem_result.sv
rtl/ememory.sv
verif/ememory_tb.sv
